/* logic/spis_pkg.sv */
/*
 * SPI slave register/buffer block constants
 * address map, word and count widths, buffer depth, CSR field positions
 */
package spis_pkg;

	//////////////////////////////
	// widths and depth
	localparam int data_w     = 32;
	localparam int addr_w     = 16;
	localparam int fifo_depth = 16;
	localparam int ptr_w      = $clog2(fifo_depth);
	localparam int cnt_w      = ptr_w + 1;     // counts 0..depth

	//////////////////////////////
	// address map
	localparam logic [addr_w-1:0] wbuf_lo    = 16'h0200;
	localparam logic [addr_w-1:0] wbuf_hi    = 16'h09ff;
	localparam logic [addr_w-1:0] rbuf_lo    = 16'h1000;
	localparam logic [addr_w-1:0] rbuf_hi    = 16'h17ff;
	localparam logic [addr_w-1:0] reg_cmd    = 16'h0000;
	localparam logic [addr_w-1:0] reg_status = 16'h0004;
	localparam logic [addr_w-1:0] reg_ctrl   = 16'h0008;

	localparam logic [data_w-1:0] empty_word = 32'hdeadbeef; // empty read buffer

	//////////////////////////////
	// command register fields
	localparam int cmd_brst_hi = 31;
	localparam int cmd_brst_lo = 24;
	localparam int cmd_sel_hi  = 20;
	localparam int cmd_sel_lo  = 19;
	localparam int cmd_ofs_hi  = 18;
	localparam int cmd_ofs_lo  = 2;
	localparam int cmd_rdnwr   = 1;
	localparam int cmd_vld     = 0;

	// status register fields
	localparam int st_wovf    = 0;
	localparam int st_wudf    = 1;
	localparam int st_rovf    = 2;
	localparam int st_rudf    = 3;
	localparam int st_wcnt_lo = 8;
	localparam int st_rcnt_lo = 16;

	// control register fields
	localparam int ctrl_wrst = 0;
	localparam int ctrl_rrst = 1;

endpackage

/* logic/spi_word_port.sv */
/*
 * SPI word port
 * takes one word access per four-phase req/ack handshake and routes it
 * to the write buffer, the read buffer or the CSR file
 */
`timescale 1ns/1ns

module spi_word_port (
	input  logic                          s_avmm_clk,
	input  logic                          s_avmm_rst_n,
	input  logic                          spi_req,
	input  logic                          spi_wr,
	input  logic [spis_pkg::addr_w-1:0]   spi_addr,
	input  logic [spis_pkg::data_w-1:0]   spi_wdata,
	output logic                          spi_ack,
	output logic [spis_pkg::data_w-1:0]   spi_rdata,
	output logic                          wbuf_push,
	output logic [spis_pkg::data_w-1:0]   wbuf_wdata,
	input  logic                          wbuf_full,
	output logic                          rbuf_pop,
	input  logic [spis_pkg::data_w-1:0]   rbuf_rdata,
	input  logic                          rbuf_empty,
	output logic                          csr_wr,
	output logic                          csr_rd,
	output logic [spis_pkg::addr_w-1:0]   csr_addr,
	output logic [spis_pkg::data_w-1:0]   csr_wdata,
	input  logic [spis_pkg::data_w-1:0]   csr_rdata
);

	logic req_meta;
	logic req_sync;
	logic req_dly;     // edge detect stage
	logic access;      // one cycle, fields are stable here
	logic access_dly;
	logic in_wbuf;
	logic in_rbuf;

	//////////////////////////////
	// req sync and ack sequence
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			req_meta   <= 1'b0;
			req_sync   <= 1'b0;
			req_dly    <= 1'b0;
			access     <= 1'b0;
			access_dly <= 1'b0;
			spi_ack    <= 1'b0;
		end else begin
			req_meta   <= spi_req;
			req_sync   <= req_meta;
			req_dly    <= req_sync;
			access     <= req_sync & ~req_dly;
			access_dly <= access;
			if (access_dly)
				spi_ack <= 1'b1;
			else if (!req_dly)
				spi_ack <= 1'b0;   // master has dropped req
		end
	end

	// address windows
	assign in_wbuf = (spi_addr >= spis_pkg::wbuf_lo) && (spi_addr <= spis_pkg::wbuf_hi);
	assign in_rbuf = (spi_addr >= spis_pkg::rbuf_lo) && (spi_addr <= spis_pkg::rbuf_hi);

	// the write buffer drops a push when full and flags it
	assign wbuf_push  = access & spi_wr & in_wbuf;
	assign wbuf_wdata = spi_wdata;
	assign rbuf_pop   = access & ~spi_wr & in_rbuf;

	assign csr_wr    = access & spi_wr & ~in_wbuf;
	assign csr_rd    = access & ~spi_wr & ~in_rbuf;
	assign csr_addr  = spi_addr;
	assign csr_wdata = spi_wdata;

	//////////////////////////////
	// read data, held through ack
	always_ff @(posedge s_avmm_clk) begin
		if (access) begin
			if (spi_wr)
				spi_rdata <= {{(spis_pkg::data_w-1){1'b0}}, in_wbuf & wbuf_full}; // drop status
			else if (!in_rbuf)
				spi_rdata <= csr_rdata;
			else if (rbuf_empty)
				spi_rdata <= spis_pkg::empty_word;
			else
				spi_rdata <= rbuf_rdata;   // fall-through head word
		end
	end

endmodule

/* logic/word_fifo.sv */
/*
 * word FIFO
 * register array buffer with fill count, full/empty, over/underflow
 * pulses and a synchronous soft reset
 */
`timescale 1ns/1ns

module word_fifo (
	input  logic                          s_avmm_clk,
	input  logic                          s_avmm_rst_n,
	input  logic                          soft_rst,
	input  logic                          push,
	input  logic [spis_pkg::data_w-1:0]   wdata,
	input  logic                          pop,
	output logic [spis_pkg::data_w-1:0]   rdata,
	output logic [spis_pkg::cnt_w-1:0]    count,
	output logic                          full,
	output logic                          empty,
	output logic                          overflow_pulse,
	output logic                          underflow_pulse
);

	logic [spis_pkg::data_w-1:0] mem [spis_pkg::fifo_depth];
	logic [spis_pkg::ptr_w-1:0]  wr_ptr;
	logic [spis_pkg::ptr_w-1:0]  rd_ptr;
	logic                        do_push;
	logic                        do_pop;

	assign full  = (count == spis_pkg::cnt_w'(spis_pkg::fifo_depth));
	assign empty = (count == '0);

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// rejected accesses
	assign overflow_pulse  = push & full;
	assign underflow_pulse = pop & empty;

	assign rdata = mem[rd_ptr];   // first word falls through

	//////////////////////////////
	// storage
	always_ff @(posedge s_avmm_clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	//////////////////////////////
	// pointers and count
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (soft_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/spis_csr.sv */
/*
 * SPI slave CSR file
 * command register driving the channel engine, status with sticky
 * buffer flags and fill counts, self-clearing buffer soft resets
 */
`timescale 1ns/1ns

module spis_csr (
	input  logic                          s_avmm_clk,
	input  logic                          s_avmm_rst_n,
	input  logic                          csr_wr,
	input  logic                          csr_rd,
	input  logic [spis_pkg::addr_w-1:0]   csr_addr,
	input  logic [spis_pkg::data_w-1:0]   csr_wdata,
	output logic [spis_pkg::data_w-1:0]   csr_rdata,
	input  logic [spis_pkg::cnt_w-1:0]    wbuf_count,
	input  logic [spis_pkg::cnt_w-1:0]    rbuf_count,
	input  logic                          wbuf_ovf_pulse,
	input  logic                          wbuf_udf_pulse,
	input  logic                          rbuf_ovf_pulse,
	input  logic                          rbuf_udf_pulse,
	output logic                          wbuf_soft_rst,
	output logic                          rbuf_soft_rst,
	input  logic                          avmm_done,
	output logic [spis_pkg::cmd_brst_hi-spis_pkg::cmd_brst_lo:0] avmm_brstlen,
	output logic [spis_pkg::cmd_sel_hi-spis_pkg::cmd_sel_lo:0]   avmm_sel,
	output logic [spis_pkg::cmd_ofs_hi-spis_pkg::cmd_ofs_lo:0]   avmm_offset,
	output logic                          avmm_rdnwr,
	output logic                          avmm_transvld
);

	logic [spis_pkg::data_w-1:0]  cmd_q;
	logic [spis_pkg::st_rudf:0]   sticky;
	logic [spis_pkg::st_rudf:0]   sticky_set;
	logic [spis_pkg::st_rudf:0]   sticky_clr;
	logic [spis_pkg::data_w-1:0]  status_word;
	logic [spis_pkg::data_w-1:0]  ctrl_word;
	logic                         cmd_wr;
	logic                         status_wr;
	logic                         ctrl_wr;

	assign cmd_wr    = csr_wr & (csr_addr == spis_pkg::reg_cmd);
	assign status_wr = csr_wr & (csr_addr == spis_pkg::reg_status);
	assign ctrl_wr   = csr_wr & (csr_addr == spis_pkg::reg_ctrl);

	//////////////////////////////
	// command register
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			cmd_q <= '0;
		end else if (cmd_wr) begin
			cmd_q <= csr_wdata;
		end else if (avmm_done) begin
			cmd_q[spis_pkg::cmd_vld] <= 1'b0;   // engine finished the transaction
		end
	end

	assign avmm_brstlen  = cmd_q[spis_pkg::cmd_brst_hi:spis_pkg::cmd_brst_lo];
	assign avmm_sel      = cmd_q[spis_pkg::cmd_sel_hi:spis_pkg::cmd_sel_lo];
	assign avmm_offset   = cmd_q[spis_pkg::cmd_ofs_hi:spis_pkg::cmd_ofs_lo];
	assign avmm_rdnwr    = cmd_q[spis_pkg::cmd_rdnwr];
	assign avmm_transvld = cmd_q[spis_pkg::cmd_vld];

	//////////////////////////////
	// sticky flags, write 1 to clear
	always_comb begin
		sticky_set                    = '0;
		sticky_set[spis_pkg::st_wovf] = wbuf_ovf_pulse;
		sticky_set[spis_pkg::st_wudf] = wbuf_udf_pulse;
		sticky_set[spis_pkg::st_rovf] = rbuf_ovf_pulse;
		sticky_set[spis_pkg::st_rudf] = rbuf_udf_pulse;
	end

	assign sticky_clr = status_wr ? csr_wdata[spis_pkg::st_rudf:0] : '0;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			sticky <= '0;
		else
			sticky <= (sticky & ~sticky_clr) | sticky_set;   // a new event wins
	end

	//////////////////////////////
	// soft reset strobes
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			wbuf_soft_rst <= 1'b0;
			rbuf_soft_rst <= 1'b0;
		end else begin
			wbuf_soft_rst <= ctrl_wr & csr_wdata[spis_pkg::ctrl_wrst];
			rbuf_soft_rst <= ctrl_wr & csr_wdata[spis_pkg::ctrl_rrst];
		end
	end

	// read values
	always_comb begin
		status_word = '0;
		status_word[spis_pkg::st_rudf:0] = sticky;
		status_word[spis_pkg::st_wcnt_lo +: spis_pkg::cnt_w] = wbuf_count;
		status_word[spis_pkg::st_rcnt_lo +: spis_pkg::cnt_w] = rbuf_count;

		ctrl_word = '0;
		ctrl_word[spis_pkg::ctrl_wrst] = wbuf_soft_rst;
		ctrl_word[spis_pkg::ctrl_rrst] = rbuf_soft_rst;
	end

	always_comb begin
		csr_rdata = '0;
		if (csr_rd) begin
			case (csr_addr)
				spis_pkg::reg_cmd:    csr_rdata = cmd_q;
				spis_pkg::reg_status: csr_rdata = status_word;
				spis_pkg::reg_ctrl:   csr_rdata = ctrl_word;
				default:              csr_rdata = '0;   // unmapped
			endcase
		end
	end

endmodule

/* logic/avmm_word_port.sv */
/*
 * AVMM word port
 * four-phase req/ack port for the channel engine, fills the read
 * buffer on writes and drains the write buffer on reads
 */
`timescale 1ns/1ns

module avmm_word_port (
	input  logic                          s_avmm_clk,
	input  logic                          s_avmm_rst_n,
	input  logic                          avb_req,
	input  logic                          avb_wr,
	input  logic [spis_pkg::data_w-1:0]   avb_wdata,
	output logic                          avb_ack,
	output logic [spis_pkg::data_w-1:0]   avb_rdata,
	output logic                          rbuf_push,
	output logic [spis_pkg::data_w-1:0]   rbuf_wdata,
	input  logic                          rbuf_full,
	output logic                          wbuf_pop,
	input  logic [spis_pkg::data_w-1:0]   wbuf_rdata,
	input  logic                          wbuf_empty
);

	logic req_meta;
	logic req_sync;
	logic req_dly;
	logic access;
	logic access_dly;

	//////////////////////////////
	// req sync and ack sequence
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			req_meta   <= 1'b0;
			req_sync   <= 1'b0;
			req_dly    <= 1'b0;
			access     <= 1'b0;
			access_dly <= 1'b0;
			avb_ack    <= 1'b0;
		end else begin
			req_meta   <= avb_req;
			req_sync   <= req_meta;
			req_dly    <= req_sync;
			access     <= req_sync & ~req_dly;   // rising edge of req
			access_dly <= access;
			if (access_dly)
				avb_ack <= 1'b1;
			else if (!req_dly)
				avb_ack <= 1'b0;
		end
	end

	// full and empty are handled inside the FIFO, which also flags them
	assign rbuf_push  = access & avb_wr;
	assign rbuf_wdata = avb_wdata;
	assign wbuf_pop   = access & ~avb_wr;

	//////////////////////////////
	// read data
	always_ff @(posedge s_avmm_clk) begin
		if (access) begin
			if (avb_wr)
				avb_rdata <= {{(spis_pkg::data_w-1){1'b0}}, rbuf_full};  // word dropped
			else if (wbuf_empty)
				avb_rdata <= '0;
			else
				avb_rdata <= wbuf_rdata;
		end
	end

endmodule

/* logic/spis_regbuf_top.sv */
/*
 * SPI slave register and buffer block
 * SPI and AVMM word ports around two word buffers and the CSR file
 */
`timescale 1ns/1ns

module spis_regbuf_top (
	input  logic                          s_avmm_clk,
	input  logic                          s_avmm_rst_n,
	// SPI word side
	input  logic                          spi_req,
	input  logic                          spi_wr,
	input  logic [spis_pkg::addr_w-1:0]   spi_addr,
	input  logic [spis_pkg::data_w-1:0]   spi_wdata,
	output logic                          spi_ack,
	output logic [spis_pkg::data_w-1:0]   spi_rdata,
	// AVMM word side
	input  logic                          avb_req,
	input  logic                          avb_wr,
	input  logic [spis_pkg::data_w-1:0]   avb_wdata,
	output logic                          avb_ack,
	output logic [spis_pkg::data_w-1:0]   avb_rdata,
	// channel engine
	input  logic                          avmm_done,
	output logic [spis_pkg::cmd_brst_hi-spis_pkg::cmd_brst_lo:0] avmm_brstlen,
	output logic [spis_pkg::cmd_sel_hi-spis_pkg::cmd_sel_lo:0]   avmm_sel,
	output logic [spis_pkg::cmd_ofs_hi-spis_pkg::cmd_ofs_lo:0]   avmm_offset,
	output logic                          avmm_rdnwr,
	output logic                          avmm_transvld
);

	// write buffer, SPI in / AVMM out
	logic                         wbuf_push, wbuf_pop, wbuf_full, wbuf_empty;
	logic [spis_pkg::data_w-1:0]  wbuf_wdata, wbuf_rdata;
	logic [spis_pkg::cnt_w-1:0]   wbuf_count;
	logic                         wbuf_ovf, wbuf_udf, wbuf_soft_rst;
	// read buffer, AVMM in / SPI out
	logic                         rbuf_push, rbuf_pop, rbuf_full, rbuf_empty;
	logic [spis_pkg::data_w-1:0]  rbuf_wdata, rbuf_rdata;
	logic [spis_pkg::cnt_w-1:0]   rbuf_count;
	logic                         rbuf_ovf, rbuf_udf, rbuf_soft_rst;
	// CSR access
	logic                         csr_wr, csr_rd;
	logic [spis_pkg::addr_w-1:0]  csr_addr;
	logic [spis_pkg::data_w-1:0]  csr_wdata, csr_rdata;

	spi_word_port u_spi_port (
		.s_avmm_clk, .s_avmm_rst_n,
		.spi_req, .spi_wr, .spi_addr, .spi_wdata, .spi_ack, .spi_rdata,
		.wbuf_push, .wbuf_wdata, .wbuf_full,
		.rbuf_pop, .rbuf_rdata, .rbuf_empty,
		.csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata
	);

	word_fifo u_wbuf (
		.s_avmm_clk, .s_avmm_rst_n,
		.soft_rst        (wbuf_soft_rst),
		.push            (wbuf_push),
		.wdata           (wbuf_wdata),
		.pop             (wbuf_pop),
		.rdata           (wbuf_rdata),
		.count           (wbuf_count),
		.full            (wbuf_full),
		.empty           (wbuf_empty),
		.overflow_pulse  (wbuf_ovf),
		.underflow_pulse (wbuf_udf)
	);

	word_fifo u_rbuf (
		.s_avmm_clk, .s_avmm_rst_n,
		.soft_rst        (rbuf_soft_rst),
		.push            (rbuf_push),
		.wdata           (rbuf_wdata),
		.pop             (rbuf_pop),
		.rdata           (rbuf_rdata),
		.count           (rbuf_count),
		.full            (rbuf_full),
		.empty           (rbuf_empty),
		.overflow_pulse  (rbuf_ovf),
		.underflow_pulse (rbuf_udf)
	);

	spis_csr u_csr (
		.s_avmm_clk, .s_avmm_rst_n,
		.csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
		.wbuf_count, .rbuf_count,
		.wbuf_ovf_pulse (wbuf_ovf),
		.wbuf_udf_pulse (wbuf_udf),
		.rbuf_ovf_pulse (rbuf_ovf),
		.rbuf_udf_pulse (rbuf_udf),
		.wbuf_soft_rst, .rbuf_soft_rst,
		.avmm_done, .avmm_brstlen, .avmm_sel, .avmm_offset, .avmm_rdnwr, .avmm_transvld
	);

	avmm_word_port u_avmm_port (
		.s_avmm_clk, .s_avmm_rst_n,
		.avb_req, .avb_wr, .avb_wdata, .avb_ack, .avb_rdata,
		.rbuf_push, .rbuf_wdata, .rbuf_full,
		.wbuf_pop, .wbuf_rdata, .wbuf_empty
	);

endmodule

/* tests/tb_clkgen.sv */
/*
 * testbench clock and reset source
 * 8 ns clock, reset held low for the first cycles
 */
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int rst_cycles = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;   // release away from the sampling edge
	end

endmodule

/* tests/spis_checker.sv */
/*
 * SPI slave register/buffer checker
 * reference model of both buffers, the command register and the sticky
 * flags, compared at every completed handshake
 */
`timescale 1ns/1ns

module spis_checker (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          spi_req,
	input  logic                          spi_wr,
	input  logic [spis_pkg::addr_w-1:0]   spi_addr,
	input  logic [spis_pkg::data_w-1:0]   spi_wdata,
	input  logic                          spi_ack,
	input  logic [spis_pkg::data_w-1:0]   spi_rdata,
	input  logic                          avb_req,
	input  logic                          avb_wr,
	input  logic [spis_pkg::data_w-1:0]   avb_wdata,
	input  logic                          avb_ack,
	input  logic [spis_pkg::data_w-1:0]   avb_rdata,
	input  logic                          avmm_done,
	input  logic [spis_pkg::cmd_brst_hi-spis_pkg::cmd_brst_lo:0] avmm_brstlen,
	input  logic [spis_pkg::cmd_sel_hi-spis_pkg::cmd_sel_lo:0]   avmm_sel,
	input  logic [spis_pkg::cmd_ofs_hi-spis_pkg::cmd_ofs_lo:0]   avmm_offset,
	input  logic                          avmm_rdnwr,
	input  logic                          avmm_transvld,
	input  logic                          report,
	output int                            error_count
);

	localparam int stuck_limit = 16;   // a handshake edge should follow within a few cycles

	logic [spis_pkg::data_w-1:0]  wq[$];   // write buffer model
	logic [spis_pkg::data_w-1:0]  rq[$];   // read buffer model
	logic [spis_pkg::data_w-1:0]  cmd_m    = '0;
	logic [spis_pkg::st_rudf:0]   sticky_m = '0;
	logic spi_ack_q = 1'b0;
	logic avb_ack_q = 1'b0;
	logic done_q    = 1'b0;
	logic rst_seen  = 1'b0;
	int   spi_gap   = 0;
	int   avb_gap   = 0;
	int   errors    = 0;
	int   checks    = 0;
	int   spi_cnt   = 0;
	int   avb_cnt   = 0;

	assign error_count = errors;

	function automatic logic in_window(input logic [spis_pkg::addr_w-1:0] addr,
			input logic [spis_pkg::addr_w-1:0] lo, input logic [spis_pkg::addr_w-1:0] hi);
		return (addr >= lo) && (addr <= hi);
	endfunction

	function automatic logic [spis_pkg::data_w-1:0] status_model();
		logic [spis_pkg::data_w-1:0] w;
		w = '0;
		w[spis_pkg::st_rudf:0] = sticky_m;
		w[spis_pkg::st_wcnt_lo +: spis_pkg::cnt_w] = spis_pkg::cnt_w'(wq.size());
		w[spis_pkg::st_rcnt_lo +: spis_pkg::cnt_w] = spis_pkg::cnt_w'(rq.size());
		return w;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_channel_outputs();
		compare("avmm_brstlen", {24'b0, cmd_m[spis_pkg::cmd_brst_hi:spis_pkg::cmd_brst_lo]},
			{24'b0, avmm_brstlen});
		compare("avmm_sel", {30'b0, cmd_m[spis_pkg::cmd_sel_hi:spis_pkg::cmd_sel_lo]},
			{30'b0, avmm_sel});
		compare("avmm_offset", {15'b0, cmd_m[spis_pkg::cmd_ofs_hi:spis_pkg::cmd_ofs_lo]},
			{15'b0, avmm_offset});
		compare("avmm_rdnwr", {31'b0, cmd_m[spis_pkg::cmd_rdnwr]}, {31'b0, avmm_rdnwr});
		compare("avmm_transvld", {31'b0, cmd_m[spis_pkg::cmd_vld]}, {31'b0, avmm_transvld});
	endtask

	//////////////////////////////
	// SPI side, one completed access
	task automatic spi_complete();
		logic [spis_pkg::data_w-1:0] exp;
		exp = '0;
		spi_cnt++;
		if (spi_wr) begin
			if (in_window(spi_addr, spis_pkg::wbuf_lo, spis_pkg::wbuf_hi)) begin
				if (wq.size() == spis_pkg::fifo_depth) begin
					exp[0] = 1'b1;   // word dropped
					sticky_m[spis_pkg::st_wovf] = 1'b1;
				end else begin
					wq.push_back(spi_wdata);
				end
			end else if (spi_addr == spis_pkg::reg_cmd) begin
				cmd_m = spi_wdata;
			end else if (spi_addr == spis_pkg::reg_status) begin
				sticky_m = sticky_m & ~spi_wdata[spis_pkg::st_rudf:0];
			end else if (spi_addr == spis_pkg::reg_ctrl) begin
				if (spi_wdata[spis_pkg::ctrl_wrst])
					wq.delete();
				if (spi_wdata[spis_pkg::ctrl_rrst])
					rq.delete();
			end
		end else if (in_window(spi_addr, spis_pkg::rbuf_lo, spis_pkg::rbuf_hi)) begin
			if (rq.size() == 0) begin
				exp = spis_pkg::empty_word;
				sticky_m[spis_pkg::st_rudf] = 1'b1;
			end else begin
				exp = rq.pop_front();
			end
		end else if (spi_addr == spis_pkg::reg_cmd) begin
			exp = cmd_m;
		end else if (spi_addr == spis_pkg::reg_status) begin
			exp = status_model();
		end
		compare("spi_rdata", exp, spi_rdata);
		if (spi_wr && spi_addr == spis_pkg::reg_cmd)
			check_channel_outputs();
	endtask

	// AVMM side, one completed access
	task automatic avb_complete();
		logic [spis_pkg::data_w-1:0] exp;
		exp = '0;
		avb_cnt++;
		if (avb_wr) begin
			if (rq.size() == spis_pkg::fifo_depth) begin
				exp[0] = 1'b1;
				sticky_m[spis_pkg::st_rovf] = 1'b1;
			end else begin
				rq.push_back(avb_wdata);
			end
		end else if (wq.size() == 0) begin
			sticky_m[spis_pkg::st_wudf] = 1'b1;   // reads as zero
		end else begin
			exp = wq.pop_front();
		end
		compare("avb_rdata", exp, avb_rdata);
	endtask

	task automatic watch_stuck(input string side, input logic req, input logic ack,
			inout int gap);
		if (req != ack)
			gap++;
		else
			gap = 0;
		if (gap == stuck_limit) begin
			errors++;
			$display("%s handshake stuck: ack did not follow req for %0d cycles at t=%0t",
				side, stuck_limit, $time);
		end
	endtask

	//////////////////////////////
	// sampled on the rising edge, before the DUT updates
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wq.delete();
			rq.delete();
			cmd_m     = '0;
			sticky_m  = '0;
			spi_ack_q = 1'b0;
			avb_ack_q = 1'b0;
			done_q    = 1'b0;
			rst_seen  = 1'b0;
			spi_gap   = 0;
			avb_gap   = 0;
		end else begin
			if (!rst_seen) begin
				check_channel_outputs();   // state right after reset
				rst_seen = 1'b1;
			end
			if (done_q)
				compare("avmm_transvld", {31'b0, cmd_m[spis_pkg::cmd_vld]},
					{31'b0, avmm_transvld});
			done_q = avmm_done;
			if (avmm_done)
				cmd_m[spis_pkg::cmd_vld] = 1'b0;
			if (spi_ack && !spi_ack_q)
				spi_complete();
			if (avb_ack && !avb_ack_q)
				avb_complete();
			spi_ack_q = spi_ack;
			avb_ack_q = avb_ack;
			watch_stuck("SPI", spi_req, spi_ack, spi_gap);
			watch_stuck("AVMM", avb_req, avb_ack, avb_gap);
		end
	end

	always @(posedge report) begin
		$display("checker summary: %0d errors in %0d checks, %0d SPI and %0d AVMM handshakes",
			errors, checks, spi_cnt, avb_cnt);
	end

endmodule

/* tests/spis_tb.sv */
/*
 * SPI slave register/buffer testbench
 * seeded random traffic on both word ports, checked by spis_checker
 */
`timescale 1ns/1ns

module spis_tb;

	localparam int rst_cycles  = 5;
	localparam int xfer_cycles = 40;   // cycle budget per handshake
	localparam int wbuf_span   = int'(spis_pkg::wbuf_hi) - int'(spis_pkg::wbuf_lo);
	localparam int rbuf_span   = int'(spis_pkg::rbuf_hi) - int'(spis_pkg::rbuf_lo);

	logic clk;
	logic rst_n;
	logic                          spi_req   = 1'b0;
	logic                          spi_wr    = 1'b0;
	logic [spis_pkg::addr_w-1:0]   spi_addr  = '0;
	logic [spis_pkg::data_w-1:0]   spi_wdata = '0;
	logic                          spi_ack;
	logic [spis_pkg::data_w-1:0]   spi_rdata;
	logic                          avb_req   = 1'b0;
	logic                          avb_wr    = 1'b0;
	logic [spis_pkg::data_w-1:0]   avb_wdata = '0;
	logic                          avb_ack;
	logic [spis_pkg::data_w-1:0]   avb_rdata;
	logic                          avmm_done = 1'b0;
	logic [spis_pkg::cmd_brst_hi-spis_pkg::cmd_brst_lo:0] avmm_brstlen;
	logic [spis_pkg::cmd_sel_hi-spis_pkg::cmd_sel_lo:0]   avmm_sel;
	logic [spis_pkg::cmd_ofs_hi-spis_pkg::cmd_ofs_lo:0]   avmm_offset;
	logic avmm_rdnwr;
	logic avmm_transvld;
	logic tests_done = 1'b0;
	logic report     = 1'b0;
	int   error_count;
	int   issued     = 0;
	int   cycles     = 0;

	tb_clkgen #(.rst_cycles(rst_cycles)) u_clkgen (.clk(clk), .rst_n(rst_n));

	spis_regbuf_top dut (
		.s_avmm_clk(clk), .s_avmm_rst_n(rst_n),
		.spi_req, .spi_wr, .spi_addr, .spi_wdata, .spi_ack, .spi_rdata,
		.avb_req, .avb_wr, .avb_wdata, .avb_ack, .avb_rdata,
		.avmm_done, .avmm_brstlen, .avmm_sel, .avmm_offset, .avmm_rdnwr, .avmm_transvld
	);

	spis_checker u_chk (
		.clk, .rst_n,
		.spi_req, .spi_wr, .spi_addr, .spi_wdata, .spi_ack, .spi_rdata,
		.avb_req, .avb_wr, .avb_wdata, .avb_ack, .avb_rdata,
		.avmm_done, .avmm_brstlen, .avmm_sel, .avmm_offset, .avmm_rdnwr, .avmm_transvld,
		.report, .error_count
	);

	//////////////////////////////
	// handshake drivers, falling edge
	task automatic spi_xfer(input logic wr, input logic [spis_pkg::addr_w-1:0] addr,
			input logic [spis_pkg::data_w-1:0] wdata);
		@(negedge clk);
		spi_wr    = wr;
		spi_addr  = addr;
		spi_wdata = wdata;
		spi_req   = 1'b1;
		issued++;
		while (!spi_ack) @(negedge clk);
		spi_req = 1'b0;   // fields stay put until the next request
		while (spi_ack) @(negedge clk);
	endtask

	task automatic avb_xfer(input logic wr, input logic [spis_pkg::data_w-1:0] wdata);
		@(negedge clk);
		avb_wr    = wr;
		avb_wdata = wdata;
		avb_req   = 1'b1;
		issued++;
		while (!avb_ack) @(negedge clk);
		avb_req = 1'b0;
		while (avb_ack) @(negedge clk);
	endtask

	task automatic pulse_done();
		@(negedge clk);
		avmm_done = 1'b1;
		@(negedge clk);
		avmm_done = 1'b0;
	endtask

	function automatic logic [spis_pkg::addr_w-1:0] wbuf_addr();
		return spis_pkg::wbuf_lo + 16'($urandom_range(0, wbuf_span));
	endfunction

	function automatic logic [spis_pkg::addr_w-1:0] rbuf_addr();
		return spis_pkg::rbuf_lo + 16'($urandom_range(0, rbuf_span));
	endfunction

	// gap between the write and read windows
	function automatic logic [spis_pkg::addr_w-1:0] unmapped_addr();
		return 16'h0a00 + 16'($urandom_range(0, 32'h5ff));
	endfunction

	//////////////////////////////
	// stimulus
	initial begin : stimulus
		logic [spis_pkg::data_w-1:0] word;
		int n;
		void'($urandom(32'h8e6a4685));
		@(posedge rst_n);

		// reset values and unmapped reads
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		spi_xfer(1'b0, spis_pkg::reg_cmd, '0);
		spi_xfer(1'b0, spis_pkg::reg_ctrl, '0);
		spi_xfer(1'b0, 16'h000c, '0);
		spi_xfer(1'b0, 16'hfffc, '0);
		repeat (4) spi_xfer(1'b0, unmapped_addr(), '0);

		// command register and channel outputs
		for (int i = 0; i < 8; i++) begin
			word = $urandom();
			word[spis_pkg::cmd_vld] = i[0];
			spi_xfer(1'b1, spis_pkg::reg_cmd, word);
			spi_xfer(1'b0, spis_pkg::reg_cmd, '0);
			pulse_done();
			spi_xfer(1'b0, spis_pkg::reg_cmd, '0);
		end

		// SPI to AVMM through the write buffer, one extra empty read each
		repeat (4) begin
			n = $urandom_range(1, 12);
			repeat (n) spi_xfer(1'b1, wbuf_addr(), $urandom());
			repeat (n + 1) avb_xfer(1'b0, '0);
		end
		// AVMM to SPI through the read buffer
		repeat (4) begin
			n = $urandom_range(1, 12);
			repeat (n) avb_xfer(1'b1, $urandom());
			repeat (n + 1) spi_xfer(1'b0, rbuf_addr(), '0);
		end
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		spi_xfer(1'b1, spis_pkg::reg_status, 32'hffffffff);

		// overflow and underflow on both buffers
		repeat (spis_pkg::fifo_depth + 1) spi_xfer(1'b1, wbuf_addr(), $urandom());
		repeat (spis_pkg::fifo_depth + 1) avb_xfer(1'b1, $urandom());
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		repeat (spis_pkg::fifo_depth + 1) avb_xfer(1'b0, '0);
		repeat (spis_pkg::fifo_depth + 1) spi_xfer(1'b0, rbuf_addr(), '0);
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		spi_xfer(1'b1, spis_pkg::reg_status, 32'hffffffff);
		spi_xfer(1'b0, spis_pkg::reg_status, '0);

		// soft resets, one buffer at a time
		repeat (5) spi_xfer(1'b1, wbuf_addr(), $urandom());
		repeat (5) avb_xfer(1'b1, $urandom());
		spi_xfer(1'b1, spis_pkg::reg_ctrl, 32'h1);
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		avb_xfer(1'b0, '0);
		spi_xfer(1'b1, spis_pkg::reg_ctrl, 32'h2);
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		spi_xfer(1'b0, rbuf_addr(), '0);
		spi_xfer(1'b0, spis_pkg::reg_ctrl, '0);
		spi_xfer(1'b0, spis_pkg::reg_status, '0);

		// random mix
		repeat (80) begin
			case ($urandom_range(0, 4))
				0:       spi_xfer(1'b1, wbuf_addr(), $urandom());
				1:       spi_xfer(1'b0, rbuf_addr(), '0);
				2:       avb_xfer(1'b1, $urandom());
				3:       avb_xfer(1'b0, '0);
				default: spi_xfer(1'b0, spis_pkg::reg_status, '0);
			endcase
		end
		spi_xfer(1'b0, spis_pkg::reg_status, '0);
		repeat (4) @(negedge clk);
		tests_done = 1'b1;
	end

	//////////////////////////////
	// cycle limit and end of run
	initial begin : watchdog
		// the handshake in flight counts as issued
		while (!tests_done && cycles <= xfer_cycles * (issued + 1) + rst_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (!tests_done)
			$display("timeout: run stopped after %0d cycles with %0d handshakes issued",
				cycles, issued);
		report = 1'b1;
		#1;
		if (!tests_done || error_count != 0)
			$display("Test failures found");
		else
			$display("All tests passed!");
		$finish;
	end

endmodule

/* flist.f */
logic/spis_pkg.sv
logic/spi_word_port.sv
logic/word_fifo.sv
logic/spis_csr.sv
logic/avmm_word_port.sv
logic/spis_regbuf_top.sv
tests/tb_clkgen.sv
tests/spis_checker.sv
tests/spis_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SPI slave register/buffer testbench with Verilator and run it.
# The run fails if any step fails or if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

log=sim.log
sim_bin=spis_sim

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module spis_tb -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$log"; then
	exit 1
fi
exit 0
